// File: exec_top.f
+incdir+include
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch_comparator.sv
hdl/exec_csr_update.sv
hdl/exec_stage.sv
hdl/exec_m1_latch.sv
hdl/exec_top.sv
testbench/exec_properties.sv
testbench/exec_tb.sv

// File: hdl/exec_alu.sv
/* Combinational integer ALU of the execute stage, ten RV32I register and immediate operations.
   Purely combinational, zero cycles of latency. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_alu (
    input  exec_pkg::word_t   operand_a,
    input  exec_pkg::word_t   operand_b,
    input  exec_pkg::alu_op_e operation,
    output exec_pkg::word_t   result
);

    import exec_pkg::*;

    // Shift amount from the low bits of operand b
    logic [4:0] shamt;

    // Signed view for SLT and SRA
    logic signed [`XLEN-1:0] operand_a_signed;
    logic signed [`XLEN-1:0] operand_b_signed;

    assign shamt            = operand_b[4:0];
    assign operand_a_signed = operand_a;
    assign operand_b_signed = operand_b;

    always_comb begin
        unique case (operation)
            ALU_OP_ADD:  result = operand_a + operand_b;
            ALU_OP_SUB:  result = operand_a - operand_b;
            ALU_OP_SLL:  result = operand_a << shamt;
            // Set-less-than gives a single bit, zero extended
            ALU_OP_SLT:  result = word_t'(operand_a_signed < operand_b_signed);
            ALU_OP_SLTU: result = word_t'(operand_a < operand_b);
            ALU_OP_XOR:  result = operand_a ^ operand_b;
            ALU_OP_SRL:  result = operand_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_OP_SRA:  result = word_t'(operand_a_signed >>> shamt);
            ALU_OP_OR:   result = operand_a | operand_b;
            ALU_OP_AND:  result = operand_a & operand_b;
            // Unused encodings
            default:     result = '0;
        endcase
    end

endmodule

// File: hdl/exec_branch_comparator.sv
/* Branch condition evaluation on the two register values.
   Combinational, the taken flag goes straight to the memory-stage latch. */
`timescale 1ns/1ps

module exec_branch_comparator (
    input  exec_pkg::word_t   rs1_val,
    input  exec_pkg::word_t   rs2_val,
    input  exec_pkg::cmp_op_e operation,
    output logic              taken
);

    import exec_pkg::*;

    // Shared compare results
    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign equal         = (rs1_val == rs2_val);
    assign less_signed   = ($signed(rs1_val) < $signed(rs2_val));
    assign less_unsigned = (rs1_val < rs2_val);

    always_comb begin
        unique case (operation)
            CMP_OP_EQ:  taken = equal;
            CMP_OP_NE:  taken = !equal;
            CMP_OP_LT:  taken = less_signed;
            CMP_OP_GE:  taken = !less_signed;
            CMP_OP_LTU: taken = less_unsigned;
            CMP_OP_GEU: taken = !less_unsigned;
            // Unused encodings never branch
            default:    taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/exec_csr_update.sv
/* Read-modify-write value for CSRRW/S/C and their immediate forms.
   Combinational, fed from the latched instruction in the execute stage. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_csr_update (
    input  exec_pkg::word_t       rs1_val,
    input  logic [`CSR_ZIMM_W-1:0] zimm,
    input  exec_pkg::word_t       old_val,
    input  exec_pkg::csr_op_src_e op_src,
    input  exec_pkg::csr_alu_op_e operation,
    output exec_pkg::word_t       new_val
);

    import exec_pkg::*;

    // Operand after source select
    word_t operand;

    always_comb begin
        unique case (op_src)
            CSR_OP_SRC_RS1:  operand = rs1_val;
            // Immediate is zero extended, never sign extended
            CSR_OP_SRC_ZIMM: operand = {{(`XLEN - `CSR_ZIMM_W){1'b0}}, zimm};
        endcase
    end

    always_comb begin
        unique case (operation)
            CSR_ALU_OP_PASSTHRU: new_val = operand;
            CSR_ALU_OP_BITSET:   new_val = old_val | operand;
            CSR_ALU_OP_BITCLEAR: new_val = old_val & ~operand;
            // Unused encoding leaves the CSR as it was
            default:             new_val = old_val;
        endcase
    end

endmodule

// File: hdl/exec_m1_latch.sv
/* Pipeline register between execute and the first memory stage.
   Captures the execute results on every unstalled edge and holds them under stall. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_m1_latch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  e_stall,

    // From execute
    input  logic                  e_valid,
    input  logic [`PC_WORD_W-1:0] e_pc_word,
    input  logic [`REG_IDX_W-1:0] e_rd_idx,
    input  logic                  e_rd_we,
    input  logic                  e_csr_wen,
    input  logic [`CSR_IDX_W-1:0] e_csr_idx,
    input  exec_pkg::word_t       e_rs2_val,
    input  exec_pkg::word_t       e_alu_result,
    input  logic                  e_branch_taken,
    input  exec_pkg::word_t       e_csr_new_val,

    // Toward the memory stage
    output logic                  m1_valid,
    output logic [`PC_WORD_W-1:0] m1_pc_word,
    output logic [`REG_IDX_W-1:0] m1_rd_idx,
    output logic                  m1_rd_we,
    output logic                  m1_csr_wen,
    output logic [`CSR_IDX_W-1:0] m1_csr_idx,
    output exec_pkg::word_t       m1_rs2_val,
    output exec_pkg::word_t       m1_alu_result,
    output logic                  m1_branch_taken,
    output exec_pkg::word_t       m1_csr_new_val
);

    // Valid, low out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid <= 1'b0;
        end else if (!e_stall) begin
            m1_valid <= e_valid;
        end
    end

    // Payload, only meaningful while m1_valid is set
    always_ff @(posedge clk) begin
        if (!e_stall) begin
            m1_pc_word      <= e_pc_word;
            m1_rd_idx       <= e_rd_idx;
            m1_rd_we        <= e_rd_we;
            m1_csr_wen      <= e_csr_wen;
            m1_csr_idx      <= e_csr_idx;
            m1_rs2_val      <= e_rs2_val;
            m1_alu_result   <= e_alu_result;
            m1_branch_taken <= e_branch_taken;
            m1_csr_new_val  <= e_csr_new_val;
        end
    end

endmodule

// File: hdl/exec_pkg.sv
/* Types shared across the execute stage: the data word and the decoded control encodings.
   Compile before any module that imports it. */
`include "exec_consts.svh"

package exec_pkg;

    // Data word
    typedef logic [`XLEN-1:0] word_t;

    // Integer ALU operation
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'd0,
        ALU_OP_SUB  = 4'd1,
        ALU_OP_SLL  = 4'd2,
        ALU_OP_SLT  = 4'd3,
        ALU_OP_SLTU = 4'd4,
        ALU_OP_XOR  = 4'd5,
        ALU_OP_SRL  = 4'd6,
        ALU_OP_SRA  = 4'd7,
        ALU_OP_OR   = 4'd8,
        ALU_OP_AND  = 4'd9
    } alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1  = 2'd0,
        // PC word shifted back up to a byte address
        ALU_OP1_SRC_PC   = 2'd1,
        ALU_OP1_SRC_CSR  = 2'd2,
        ALU_OP1_SRC_ZERO = 2'd3
    } alu_op1_src_e;

    // Second ALU operand source
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS1  = 2'd0,
        ALU_OP2_SRC_RS2  = 2'd1,
        ALU_OP2_SRC_IMM  = 2'd2,
        // Link address increment
        ALU_OP2_SRC_FOUR = 2'd3
    } alu_op2_src_e;

    // Branch condition
    typedef enum logic [2:0] {
        CMP_OP_EQ  = 3'd0,
        CMP_OP_NE  = 3'd1,
        CMP_OP_LT  = 3'd2,
        CMP_OP_GE  = 3'd3,
        CMP_OP_LTU = 3'd4,
        CMP_OP_GEU = 3'd5
    } cmp_op_e;

    // CSR operand source, register or zero-extended immediate
    typedef enum logic {
        CSR_OP_SRC_RS1  = 1'b0,
        CSR_OP_SRC_ZIMM = 1'b1
    } csr_op_src_e;

    // CSR modify operation
    typedef enum logic [1:0] {
        CSR_ALU_OP_PASSTHRU = 2'd0,
        CSR_ALU_OP_BITSET   = 2'd1,
        CSR_ALU_OP_BITCLEAR = 2'd2
    } csr_alu_op_e;

endpackage

// File: hdl/exec_stage.sv
/* Execute stage: latches the decoded instruction, muxes the ALU operands and runs the ALU,
   branch comparator and CSR unit. Results are combinational from the input flop. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_stage (
    input  logic                         clk,
    input  logic                         rst_n,

    // Hazard control
    input  logic                         e_stall,
    input  logic                         e_flush,

    // From decode
    input  logic                         d_valid,
    input  logic [`PC_WORD_W-1:0]        d_pc_word,
    input  exec_pkg::word_t              d_rs1_val,
    input  exec_pkg::word_t              d_rs2_val,
    input  exec_pkg::word_t              d_immediate,
    input  exec_pkg::word_t              d_csr_old_val,
    input  logic [`CSR_ZIMM_W-1:0]       d_csr_zimm,
    input  exec_pkg::alu_op1_src_e       d_alu_op1_src,
    input  exec_pkg::alu_op2_src_e       d_alu_op2_src,
    input  exec_pkg::alu_op_e            d_alu_op,
    input  exec_pkg::cmp_op_e            d_cmp_op,
    input  exec_pkg::csr_op_src_e        d_csr_op_src,
    input  exec_pkg::csr_alu_op_e        d_csr_alu_op,
    input  logic                         d_csr_wen,
    input  logic [`CSR_IDX_W-1:0]        d_csr_idx,
    input  logic [`REG_IDX_W-1:0]        d_rd_idx,
    input  logic                         d_rd_we,

    // To the first memory stage
    output logic                         e_valid,
    output logic [`PC_WORD_W-1:0]        e_pc_word,
    output logic [`REG_IDX_W-1:0]        e_rd_idx,
    output logic                         e_rd_we,
    output logic                         e_csr_wen,
    output logic [`CSR_IDX_W-1:0]        e_csr_idx,
    output exec_pkg::word_t              e_rs2_val,
    output exec_pkg::word_t              e_alu_result,
    output logic                         e_branch_taken,
    output exec_pkg::word_t              e_csr_new_val
);

    import exec_pkg::*;

    // Input flop contents
    logic                    ff_valid;
    logic [`PC_WORD_W-1:0]   ff_pc_word;
    word_t                   ff_rs1_val;
    word_t                   ff_rs2_val;
    word_t                   ff_immediate;
    word_t                   ff_csr_old_val;
    logic [`CSR_ZIMM_W-1:0]  ff_csr_zimm;
    alu_op1_src_e            ff_alu_op1_src;
    alu_op2_src_e            ff_alu_op2_src;
    alu_op_e                 ff_alu_op;
    cmp_op_e                 ff_cmp_op;
    csr_op_src_e             ff_csr_op_src;
    csr_alu_op_e             ff_csr_alu_op;
    logic                    ff_csr_wen;
    logic [`CSR_IDX_W-1:0]   ff_csr_idx;
    logic [`REG_IDX_W-1:0]   ff_rd_idx;
    logic                    ff_rd_we;

    // ALU operands after source select
    word_t alu_operand_a;
    word_t alu_operand_b;

    // Valid bit, cleared by reset, held on stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (!e_stall) begin
            ff_valid <= d_valid;
        end
    end

    // Instruction fields, held on stall
    always_ff @(posedge clk) begin
        if (!e_stall) begin
            ff_pc_word     <= d_pc_word;
            ff_rs1_val     <= d_rs1_val;
            ff_rs2_val     <= d_rs2_val;
            ff_immediate   <= d_immediate;
            ff_csr_old_val <= d_csr_old_val;
            ff_csr_zimm    <= d_csr_zimm;
            ff_alu_op1_src <= d_alu_op1_src;
            ff_alu_op2_src <= d_alu_op2_src;
            ff_alu_op      <= d_alu_op;
            ff_cmp_op      <= d_cmp_op;
            ff_csr_op_src  <= d_csr_op_src;
            ff_csr_alu_op  <= d_csr_alu_op;
            ff_csr_wen     <= d_csr_wen;
            ff_csr_idx     <= d_csr_idx;
            ff_rd_idx      <= d_rd_idx;
            ff_rd_we       <= d_rd_we;
        end
    end

    // Operand one
    always_comb begin
        unique case (ff_alu_op1_src)
            ALU_OP1_SRC_RS1:  alu_operand_a = ff_rs1_val;
            // Byte address of the instruction
            ALU_OP1_SRC_PC:   alu_operand_a = {ff_pc_word, 2'b00};
            ALU_OP1_SRC_CSR:  alu_operand_a = ff_csr_old_val;
            ALU_OP1_SRC_ZERO: alu_operand_a = '0;
        endcase
    end

    // Operand two
    always_comb begin
        unique case (ff_alu_op2_src)
            ALU_OP2_SRC_RS1:  alu_operand_b = ff_rs1_val;
            ALU_OP2_SRC_RS2:  alu_operand_b = ff_rs2_val;
            ALU_OP2_SRC_IMM:  alu_operand_b = ff_immediate;
            ALU_OP2_SRC_FOUR: alu_operand_b = word_t'(4);
        endcase
    end

    exec_alu u_alu (
        .operand_a (alu_operand_a),
        .operand_b (alu_operand_b),
        .operation (ff_alu_op),
        .result    (e_alu_result)
    );

    exec_branch_comparator u_branch_comparator (
        .rs1_val   (ff_rs1_val),
        .rs2_val   (ff_rs2_val),
        .operation (ff_cmp_op),
        .taken     (e_branch_taken)
    );

    exec_csr_update u_csr_update (
        .rs1_val   (ff_rs1_val),
        .zimm      (ff_csr_zimm),
        .old_val   (ff_csr_old_val),
        .op_src    (ff_csr_op_src),
        .operation (ff_csr_alu_op),
        .new_val   (e_csr_new_val)
    );

    // A flushed or stalled instruction is not handed on
    assign e_valid = ff_valid && !e_flush && !e_stall;

    // Fields passed through unchanged
    assign e_pc_word = ff_pc_word;
    assign e_rd_idx  = ff_rd_idx;
    assign e_rd_we   = ff_rd_we;
    assign e_csr_wen = ff_csr_wen;
    assign e_csr_idx = ff_csr_idx;
    assign e_rs2_val = ff_rs2_val;

endmodule

// File: hdl/exec_top.sv
/* Standalone execute-stage wrapper, joining the stage to its memory-stage latch.
   Decode fields go in, registered m1 results come out two edges later. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   e_stall,
    input  logic                   e_flush,

    // Decoded instruction
    input  logic                   d_valid,
    input  logic [`PC_WORD_W-1:0]  d_pc_word,
    input  exec_pkg::word_t        d_rs1_val,
    input  exec_pkg::word_t        d_rs2_val,
    input  exec_pkg::word_t        d_immediate,
    input  exec_pkg::word_t        d_csr_old_val,
    input  logic [`CSR_ZIMM_W-1:0] d_csr_zimm,
    input  exec_pkg::alu_op1_src_e d_alu_op1_src,
    input  exec_pkg::alu_op2_src_e d_alu_op2_src,
    input  exec_pkg::alu_op_e      d_alu_op,
    input  exec_pkg::cmp_op_e      d_cmp_op,
    input  exec_pkg::csr_op_src_e  d_csr_op_src,
    input  exec_pkg::csr_alu_op_e  d_csr_alu_op,
    input  logic                   d_csr_wen,
    input  logic [`CSR_IDX_W-1:0]  d_csr_idx,
    input  logic [`REG_IDX_W-1:0]  d_rd_idx,
    input  logic                   d_rd_we,

    // Registered results
    output logic                   m1_valid,
    output logic [`PC_WORD_W-1:0]  m1_pc_word,
    output logic [`REG_IDX_W-1:0]  m1_rd_idx,
    output logic                   m1_rd_we,
    output logic                   m1_csr_wen,
    output logic [`CSR_IDX_W-1:0]  m1_csr_idx,
    output exec_pkg::word_t        m1_rs2_val,
    output exec_pkg::word_t        m1_alu_result,
    output logic                   m1_branch_taken,
    output exec_pkg::word_t        m1_csr_new_val
);

    import exec_pkg::*;

    // Execute results into the latch
    logic                  e_valid;
    logic [`PC_WORD_W-1:0] e_pc_word;
    logic [`REG_IDX_W-1:0] e_rd_idx;
    logic                  e_rd_we;
    logic                  e_csr_wen;
    logic [`CSR_IDX_W-1:0] e_csr_idx;
    word_t                 e_rs2_val;
    word_t                 e_alu_result;
    logic                  e_branch_taken;
    word_t                 e_csr_new_val;

    // Port names match the local signals one to one
    exec_stage u_stage (.*);

    exec_m1_latch u_m1_latch (.*);

endmodule

// File: include/exec_consts.svh
/* Width constants for the execute stage, shared by the package, the RTL and the testbench.
   Include wherever a field width is needed. */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data path word
`define XLEN 32

// PC without its two always-zero low bits
`define PC_WORD_W 30

// Register file index
`define REG_IDX_W 5

// CSR address and the immediate of the CSR*I forms
`define CSR_IDX_W 12
`define CSR_ZIMM_W 5

`endif

// File: testbench/exec_properties.sv
/* Concurrent checks on the control behaviour of the execute top level.
   Attached to exec_top by the bind at the end of this file. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  e_stall,
    input logic                  e_flush,
    input logic                  m1_valid,
    input logic [`PC_WORD_W-1:0] m1_pc_word,
    input logic [`REG_IDX_W-1:0] m1_rd_idx,
    input logic                  m1_rd_we,
    input logic                  m1_csr_wen,
    input logic [`CSR_IDX_W-1:0] m1_csr_idx,
    input exec_pkg::word_t       m1_rs2_val,
    input exec_pkg::word_t       m1_alu_result,
    input logic                  m1_branch_taken,
    input exec_pkg::word_t       m1_csr_new_val
);

    // Assertion failures so far, read by the testbench
    int failures = 0;

    // Synchronous reset clears valid on the reset edge
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !m1_valid)
        else begin
            failures++;
            $error("m1_valid set in the cycle after reset");
        end

    // Hazard inputs are exclusive
    stall_flush_exclusive: assert property (@(posedge clk) !(e_stall && e_flush))
        else begin
            failures++;
            $error("stall and flush high together");
        end

    // Latch holds every output across a stalled edge
    stall_holds_m1: assert property (@(posedge clk) disable iff (!rst_n)
        e_stall |=> $stable({m1_valid, m1_pc_word, m1_rd_idx, m1_rd_we, m1_csr_wen,
                             m1_csr_idx, m1_rs2_val, m1_alu_result, m1_branch_taken,
                             m1_csr_new_val}))
        else begin
            failures++;
            $error("m1 outputs changed under stall");
        end

endmodule

bind exec_top exec_properties u_properties (.*);

// File: testbench/exec_tb.sv
/* Self-checking testbench for the execute stage: seeded random decode traffic, a cycle model
   of the input flop and m1 latch, and a scoreboard on the m1 outputs. */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_tb;

    import exec_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TXN      = 3000;

    // Expected m1 payload of one instruction
    typedef struct packed {
        logic [`PC_WORD_W-1:0] pc_word;
        logic [`REG_IDX_W-1:0] rd_idx;
        logic                  rd_we;
        logic                  csr_wen;
        logic [`CSR_IDX_W-1:0] csr_idx;
        word_t                 rs2_val;
        word_t                 alu_result;
        logic                  branch_taken;
        word_t                 csr_new_val;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   e_stall;
    logic                   e_flush;
    logic                   d_valid;
    logic [`PC_WORD_W-1:0]  d_pc_word;
    word_t                  d_rs1_val;
    word_t                  d_rs2_val;
    word_t                  d_immediate;
    word_t                  d_csr_old_val;
    logic [`CSR_ZIMM_W-1:0] d_csr_zimm;
    alu_op1_src_e           d_alu_op1_src;
    alu_op2_src_e           d_alu_op2_src;
    alu_op_e                d_alu_op;
    cmp_op_e                d_cmp_op;
    csr_op_src_e            d_csr_op_src;
    csr_alu_op_e            d_csr_alu_op;
    logic                   d_csr_wen;
    logic [`CSR_IDX_W-1:0]  d_csr_idx;
    logic [`REG_IDX_W-1:0]  d_rd_idx;
    logic                   d_rd_we;
    logic                   m1_valid;
    logic [`PC_WORD_W-1:0]  m1_pc_word;
    logic [`REG_IDX_W-1:0]  m1_rd_idx;
    logic                   m1_rd_we;
    logic                   m1_csr_wen;
    logic [`CSR_IDX_W-1:0]  m1_csr_idx;
    word_t                  m1_rs2_val;
    word_t                  m1_alu_result;
    logic                   m1_branch_taken;
    word_t                  m1_csr_new_val;

    integer seed = 32'hd340;
    int     error_count = 0;
    int     check_count = 0;
    int     delivered = 0;
    int     dropped = 0;
    int     consumed = 0;

    // Two-slot model, execute flop then m1 latch
    logic    ex_valid_model;
    logic    m1_valid_model;
    expect_t m1_model;
    expect_t expect_q[$];

    exec_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    function automatic int unsigned roll(input int unsigned range);
        return $unsigned($random(seed)) % range;
    endfunction

    // Corner values mixed into plain random words
    function automatic word_t biased_word();
        case (roll(8))
            0: return '0;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return 32'h7fff_ffff;
            // Sign bit forced
            4: return $random(seed) | 32'h8000_0000;
            default: return $random(seed);
        endcase
    endfunction

    function automatic word_t model_alu(input word_t a, input word_t b, input alu_op_e op);
        int unsigned sh;
        word_t       fill;
        logic        lt_s;
        sh   = b[4:0];
        // Sign bits shifted in by SRA
        fill = a[`XLEN-1] ? ~(32'hffff_ffff >> sh) : '0;
        lt_s = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
        case (op)
            ALU_OP_ADD:  return a + b;
            ALU_OP_SUB:  return a + ~b + 1;
            ALU_OP_SLL:  return a << sh;
            ALU_OP_SLT:  return {31'b0, lt_s};
            ALU_OP_SLTU: return {31'b0, a < b};
            ALU_OP_XOR:  return a ^ b;
            ALU_OP_SRL:  return a >> sh;
            ALU_OP_SRA:  return (a >> sh) | fill;
            ALU_OP_OR:   return a | b;
            ALU_OP_AND:  return a & b;
            default:     return '0;
        endcase
    endfunction

    function automatic logic model_branch(input word_t a, input word_t b, input cmp_op_e op);
        logic lt_s;
        lt_s = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
        case (op)
            CMP_OP_EQ:  return a == b;
            CMP_OP_NE:  return a != b;
            CMP_OP_LT:  return lt_s;
            CMP_OP_GE:  return !lt_s;
            CMP_OP_LTU: return a < b;
            CMP_OP_GEU: return a >= b;
            default:    return 1'b0;
        endcase
    endfunction

    // Expected results of the instruction now on the decode inputs
    function automatic expect_t expected_from_decode();
        expect_t e;
        word_t   a;
        word_t   b;
        word_t   csr_operand;
        case (d_alu_op1_src)
            ALU_OP1_SRC_RS1: a = d_rs1_val;
            ALU_OP1_SRC_PC:  a = word_t'(d_pc_word) * 4;
            ALU_OP1_SRC_CSR: a = d_csr_old_val;
            default:         a = '0;
        endcase
        case (d_alu_op2_src)
            ALU_OP2_SRC_RS1: b = d_rs1_val;
            ALU_OP2_SRC_RS2: b = d_rs2_val;
            ALU_OP2_SRC_IMM: b = d_immediate;
            default:         b = 32'd4;
        endcase
        csr_operand = (d_csr_op_src == CSR_OP_SRC_ZIMM) ? word_t'(d_csr_zimm) : d_rs1_val;
        case (d_csr_alu_op)
            CSR_ALU_OP_PASSTHRU: e.csr_new_val = csr_operand;
            CSR_ALU_OP_BITSET:   e.csr_new_val = d_csr_old_val | csr_operand;
            default:             e.csr_new_val = d_csr_old_val & ~csr_operand;
        endcase
        e.pc_word      = d_pc_word;
        e.rd_idx       = d_rd_idx;
        e.rd_we        = d_rd_we;
        e.csr_wen      = d_csr_wen;
        e.csr_idx      = d_csr_idx;
        e.rs2_val      = d_rs2_val;
        e.alu_result   = model_alu(a, b, d_alu_op);
        e.branch_taken = model_branch(d_rs1_val, d_rs2_val, d_cmp_op);
        return e;
    endfunction

    task automatic idle_inputs();
        {e_stall, e_flush, d_valid, d_pc_word, d_rs1_val, d_rs2_val} = '0;
        {d_immediate, d_csr_old_val, d_csr_zimm, d_csr_wen, d_csr_idx} = '0;
        {d_rd_idx, d_rd_we} = '0;
        d_alu_op1_src = ALU_OP1_SRC_RS1;
        d_alu_op2_src = ALU_OP2_SRC_RS2;
        d_alu_op      = ALU_OP_ADD;
        d_cmp_op      = CMP_OP_EQ;
        d_csr_op_src  = CSR_OP_SRC_RS1;
        d_csr_alu_op  = CSR_ALU_OP_PASSTHRU;
    endtask

    task automatic drive_random();
        // Stall about 15%, flush about 10%, never together
        e_stall   = (roll(100) < 15);
        e_flush   = !e_stall && (roll(100) < 10);
        d_valid   = (roll(100) < 80);
        d_pc_word = $random(seed);
        d_rs1_val = biased_word();
        d_rs2_val = (roll(100) < 20) ? d_rs1_val : biased_word();
        d_immediate = biased_word();
        // Shift amount corners 0 and 31
        if (roll(100) < 30)
            d_immediate[4:0] = roll(2) ? 5'd31 : 5'd0;
        d_csr_old_val = biased_word();
        d_csr_zimm    = $random(seed);
        d_alu_op1_src = alu_op1_src_e'(roll(4));
        d_alu_op2_src = alu_op2_src_e'(roll(4));
        d_alu_op      = alu_op_e'(roll(10));
        d_cmp_op      = cmp_op_e'(roll(6));
        d_csr_op_src  = csr_op_src_e'(roll(2));
        d_csr_alu_op  = csr_alu_op_e'(roll(3));
        d_csr_wen     = roll(2);
        d_csr_idx     = $random(seed);
        d_rd_idx      = $random(seed);
        d_rd_we       = roll(2);
    endtask

    // Model advance on the same edge as the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            ex_valid_model = 1'b0;
            m1_valid_model = 1'b0;
            expect_q.delete();
        end else if (!e_stall) begin
            m1_valid_model = 1'b0;
            if (ex_valid_model) begin
                // Leaves execute, lands in m1 unless flushed
                m1_model       = expect_q.pop_front();
                m1_valid_model = !e_flush;
                if (e_flush)
                    dropped++;
                else
                    delivered++;
            end
            if (d_valid)
                expect_q.push_back(expected_from_decode());
            ex_valid_model = d_valid;
        end
    end

    // Instructions the DUT hands on from m1, one per unstalled edge
    always @(posedge clk) begin
        if (rst_n && !e_stall && m1_valid)
            consumed++;
    end

    // Outputs compared mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("m1_valid", m1_valid_model, m1_valid);
            if (m1_valid_model) begin
                check_value("m1_pc_word", m1_model.pc_word, m1_pc_word);
                check_value("m1_rd_idx", m1_model.rd_idx, m1_rd_idx);
                check_value("m1_rd_we", m1_model.rd_we, m1_rd_we);
                check_value("m1_csr_wen", m1_model.csr_wen, m1_csr_wen);
                check_value("m1_csr_idx", m1_model.csr_idx, m1_csr_idx);
                check_value("m1_rs2_val", m1_model.rs2_val, m1_rs2_val);
                check_value("m1_alu_result", m1_model.alu_result, m1_alu_result);
                check_value("m1_branch_taken", m1_model.branch_taken, m1_branch_taken);
                check_value("m1_csr_new_val", m1_model.csr_new_val, m1_csr_new_val);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        idle_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < NUM_TXN; i++) begin
            @(posedge clk);
            #1 drive_random();
        end
        @(posedge clk);
        #1 idle_inputs();
        // Fixed two-edge latency drains the pipe
        repeat (3) @(posedge clk);
        #1;
        // No instruction lost or handed on twice
        check_value("m1_valid_count", delivered, consumed);
        error_count += DUT.u_properties.failures;
        $display("Errors: %0d, checks: %0d, delivered: %0d, flushed: %0d",
                 error_count, check_count, delivered, dropped);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (NUM_TXN * 2 + RESET_CYCLES + 100));
        $display("Timeout: the run did not finish in time, %0d errors so far", error_count);
        $display("** FAIL **");
        $finish;
    end

endmodule
